// ==== xfcp_ram_core.f ====
design/xfcp_pkg.sv
design/wb_pkg.sv
design/xfcp_cmd_ctrl.sv
design/xfcp_word_pack.sv
design/wb_ram.sv
design/xfcp_ram_core.sv
bench/clk_rst_gen.sv
bench/xfcp_ram_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the XFCP RAM core testbench with Verilator, runs it and checks its output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f xfcp_ram_core.f \
        --top-module xfcp_ram_core_tb --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vxfcp_ram_core_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== bench/xfcp_ram_core_tb.sv ====
// Table-driven testbench for the XFCP RAM core, sends request packets and checks response bytes
`timescale 1ns/10ps

module xfcp_ram_core_tb;

    // Each packet is one literal with its first byte leftmost and at most 20 bytes
    typedef struct packed {
        logic [159:0] req;
        logic [7:0]   req_len;
        logic [159:0] rsp;
        logic [7:0]   rsp_len;
    } entry_t;

    logic                   clk;
    logic                   rst_n;
    logic                   up_valid_i;
    xfcp_pkg::xfcp_stream_t up_i;
    logic                   up_ready_o;
    logic                   down_valid_o;
    xfcp_pkg::xfcp_stream_t down_o;
    logic                   down_ready_i;

    entry_t tests[$];
    string  test_names[$];
    int     cycle_cnt = 0;
    int     timeout_limit;

    clk_rst_gen clk_rst_gen_inst (
        .clk_o(clk),
        .rst_n_o(rst_n)
    );

    xfcp_ram_core xfcp_ram_core_inst (
        .clk(clk),
        .rst_n_i(rst_n),
        .up_valid_i(up_valid_i),
        .up_i(up_i),
        .up_ready_o(up_ready_o),
        .down_valid_o(down_valid_o),
        .down_o(down_o),
        .down_ready_i(down_ready_i)
    );

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic add_test(input string name, input int req_len, input logic [159:0] req,
                            input int rsp_len, input logic [159:0] rsp);
        entry_t e;
        e.req     = req;
        e.req_len = 8'(req_len);
        e.rsp     = rsp;
        e.rsp_len = 8'(rsp_len);
        tests.push_back(e);
        test_names.push_back(name);
    endtask

    function automatic logic [7:0] byte_at(input logic [159:0] bytes, input int len,
                                           input int pos);
        return bytes[(len - 1 - pos) * 8 +: 8];
    endfunction

    task automatic fill_tests();
        add_test("wr_bank0", 8, 64'h00_12_10_00_44_33_22_11, 4, 32'h00_13_10_00);
        add_test("rd_bank0", 4, 32'h00_10_10_00, 8, 64'h00_11_10_00_44_33_22_11);
        add_test("wr_bank1", 8, 64'h01_12_10_00_DD_CC_BB_AA, 4, 32'h01_13_10_00);
        add_test("rd_bank1", 4, 32'h01_10_10_00, 8, 64'h01_11_10_00_DD_CC_BB_AA);
        add_test("rd_bank0_kept", 4, 32'h00_10_10_00, 8, 64'h00_11_10_00_44_33_22_11);
        // Four words from 0xFE land on 0xFE, 0xFF, 0x00 and 0x01
        add_test("wr_wrap", 20, {32'h00_12_FE_03, 128'h0102_0304_0506_0708_090A_0B0C_0D0E_0F10},
                 4, 32'h00_13_FE_03);
        add_test("rd_wrap_low", 4, 32'h00_10_00_01, 12, 96'h00_11_00_01_090A_0B0C_0D0E_0F10);
        add_test("rd_burst_wrap", 4, 32'h00_10_FE_03,
                 20, {32'h00_11_FE_03, 128'h0102_0304_0506_0708_090A_0B0C_0D0E_0F10});
        add_test("bad_route", 4, 32'h02_10_10_00, 2, 16'h02_FE);
        add_test("bad_opcode", 6, 48'h01_20_10_00_AA_BB, 2, 16'h01_FE);
        add_test("bad_route_wr", 8, 64'h02_12_10_00_11_22_33_44, 2, 16'h02_FE);
        add_test("rd_after_error", 4, 32'h01_10_10_00, 8, 64'h01_11_10_00_DD_CC_BB_AA);
    endtask

    // Must be called right after a rising edge
    task automatic send_request(input int idx);
        int pos;
        int len;
        pos = 0;
        len = int'(tests[idx].req_len);
        while (pos < len) begin
            up_valid_i <= 1'b1;
            up_i.data  <= byte_at(tests[idx].req, len, pos);
            up_i.last  <= (pos == len - 1);
            @(posedge clk);
            if (up_ready_o) begin
                pos++;
            end
        end
        up_valid_i <= 1'b0;
    endtask

    task automatic check_response(input int idx);
        int         pos;
        int         len;
        logic [7:0] exp_byte;
        logic       exp_last;
        pos = 0;
        len = int'(tests[idx].rsp_len);
        while (pos < len) begin
            @(posedge clk);
            // No new request is taken until the response is out
            assert (!up_ready_o)
                else begin
                    $display("ERROR %s up_ready_o: expected 0, actual %0b",
                             test_names[idx], up_ready_o);
                    stop_on_failure();
                end
            if (down_valid_o && down_ready_i) begin
                exp_byte = byte_at(tests[idx].rsp, len, pos);
                exp_last = (pos == len - 1);
                assert (down_o.data == exp_byte)
                    else begin
                        $display("ERROR %s byte %0d: expected 0x%02h, actual 0x%02h",
                                 test_names[idx], pos, exp_byte, down_o.data);
                        stop_on_failure();
                    end
                assert (down_o.last == exp_last)
                    else begin
                        $display("ERROR %s byte %0d last: expected %0b, actual %0b",
                                 test_names[idx], pos, exp_last, down_o.last);
                        stop_on_failure();
                    end
                pos++;
            end
        end
    endtask

    // Random back-pressure with ready low about one cycle in three
    initial begin
        down_ready_i = 1'b0;
        void'($urandom(32'he4b9_8c6e));
        forever begin
            @(posedge clk);
            down_ready_i <= ($urandom_range(2, 0) != 0);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < timeout_limit)
            else begin
                $display("Timeout, the DUT stopped responding after %0d cycles", cycle_cnt);
                stop_on_failure();
            end
    end

    initial begin
        int total_bytes;
        up_valid_i   = 1'b0;
        up_i         = '0;
        fill_tests();
        total_bytes = 0;
        foreach (tests[k]) begin
            total_bytes += int'(tests[k].req_len) + int'(tests[k].rsp_len);
        end
        timeout_limit = 40 * total_bytes + 5;

        wait (rst_n === 1'b1);
        @(posedge clk);
        assert (!down_valid_o)
            else begin
                $display("ERROR after_reset down_valid_o: expected 0, actual %0b", down_valid_o);
                stop_on_failure();
            end
        assert (up_ready_o)
            else begin
                $display("ERROR after_reset up_ready_o: expected 1, actual %0b", up_ready_o);
                stop_on_failure();
            end

        foreach (tests[t]) begin
            send_request(t);
            check_response(t);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== bench/clk_rst_gen.sv ====
// Testbench clock and reset source, 10 ns clock with reset held low for the first 5 cycles
`timescale 1ns/10ps

module clk_rst_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Release on a rising edge so the DUT leaves reset cleanly
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== design/xfcp_ram_core.sv ====
// Top level of the XFCP host port with its two RAM banks, instantiated by the testbench as DUT
`timescale 1ns/10ps

module xfcp_ram_core (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Request packets from the host
    input  logic                   up_valid_i,
    input  xfcp_pkg::xfcp_stream_t up_i,
    output logic                   up_ready_o,

    // Response packets to the host
    output logic                   down_valid_o,
    output xfcp_pkg::xfcp_stream_t down_o,
    input  logic                   down_ready_i
);

    wb_pkg::wb_req_t      wb_req;
    wb_pkg::wb_rsp_t      wb_rsp;

    logic                 shift_in;
    logic                 load;
    logic                 shift_out;
    xfcp_pkg::xfcp_byte_t pack_byte;
    wb_pkg::wb_data_t     pack_word;

    xfcp_cmd_ctrl
    xfcp_cmd_ctrl_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .up_valid_i(up_valid_i),
        .up_i(up_i),
        .up_ready_o(up_ready_o),
        .down_valid_o(down_valid_o),
        .down_o(down_o),
        .down_ready_i(down_ready_i),
        .wb_req_o(wb_req),
        .wb_rsp_i(wb_rsp),
        .shift_in_o(shift_in),
        .load_o(load),
        .shift_out_o(shift_out),
        .pack_byte_i(pack_byte),
        .pack_word_i(pack_word)
    );

    // Write bytes come straight off the request stream, read words off the bus
    xfcp_word_pack
    xfcp_word_pack_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .byte_i(up_i.data),
        .shift_in_i(shift_in),
        .word_o(pack_word),
        .word_i(wb_rsp.dat),
        .load_i(load),
        .shift_out_i(shift_out),
        .byte_o(pack_byte)
    );

    wb_ram
    wb_ram_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .wb_req_i(wb_req),
        .wb_rsp_o(wb_rsp)
    );

endmodule

// ==== design/wb_ram.sv ====
// Wishbone classic RAM slave with two 256-word banks and a one-cycle registered ack
`timescale 1ns/10ps

module wb_ram (
    input  logic            clk,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o
);

    // Address MSB selects the bank, the low bits index within it
    wb_pkg::wb_data_t mem [0:(2**wb_pkg::WB_ADDR_W)-1];

    wb_pkg::wb_data_t dat_q;
    logic             ack_q;
    logic             access;

    assign access = wb_req_i.cyc && wb_req_i.stb;

    always_ff @(posedge clk) begin
        // Only one write per cycle, before ack goes out
        if (access && wb_req_i.we && !ack_q) begin
            mem[wb_req_i.adr] <= wb_req_i.dat;
        end
        if (access) begin
            dat_q <= mem[wb_req_i.adr];
        end
    end

    // Ack for exactly one cycle, the master drops stb right after
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access && !ack_q;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;

endmodule

// ==== design/xfcp_word_pack.sv ====
// Byte/word shift register between the byte stream and the 32-bit bus, LSB first both ways
`timescale 1ns/10ps

module xfcp_word_pack (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // Write path, stream bytes in and bus word out
    input  xfcp_pkg::xfcp_byte_t byte_i,
    input  logic                 shift_in_i,
    output wb_pkg::wb_data_t     word_o,

    // Read path, bus word in and stream bytes out
    input  wb_pkg::wb_data_t     word_i,
    input  logic                 load_i,
    input  logic                 shift_out_i,
    output xfcp_pkg::xfcp_byte_t byte_o
);

    wb_pkg::wb_data_t word_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_q <= '0;
        end else if (load_i) begin
            word_q <= word_i;
        end else if (shift_in_i) begin
            // New byte enters at the top so the first byte ends up lowest
            word_q <= {byte_i, word_q[wb_pkg::WB_DATA_W-1:8]};
        end else if (shift_out_i) begin
            word_q <= {xfcp_pkg::xfcp_byte_t'('0), word_q[wb_pkg::WB_DATA_W-1:8]};
        end
    end

    assign word_o = word_q;

    // Next byte to send is always the low one
    assign byte_o = word_q[7:0];

endmodule

// ==== design/xfcp_cmd_ctrl.sv ====
// Command FSM that parses request packets, runs Wishbone cycles and streams back responses
`timescale 1ns/10ps

module xfcp_cmd_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   up_valid_i,
    input  xfcp_pkg::xfcp_stream_t up_i,
    output logic                   up_ready_o,

    output logic                   down_valid_o,
    output xfcp_pkg::xfcp_stream_t down_o,
    input  logic                   down_ready_i,

    output wb_pkg::wb_req_t        wb_req_o,
    input  wb_pkg::wb_rsp_t        wb_rsp_i,

    output logic                   shift_in_o,
    output logic                   load_o,
    output logic                   shift_out_o,
    input  xfcp_pkg::xfcp_byte_t   pack_byte_i,
    input  wb_pkg::wb_data_t       pack_word_i
);

    typedef enum logic [2:0] {
        ST_HDR,
        ST_WDATA,
        ST_BUS,
        ST_RSP_HDR,
        ST_RDATA,
        ST_ERR,
        ST_DRAIN
    } state_t;

    state_t state;

    // Captured request header
    xfcp_pkg::xfcp_byte_t route_q;
    xfcp_pkg::xfcp_byte_t op_q;
    xfcp_pkg::xfcp_byte_t addr_q;
    xfcp_pkg::xfcp_byte_t count_q;

    // Running word address within the bank, wraps at 0xFF
    logic [wb_pkg::WB_ADDR_W-2:0] word_addr;
    // Words still to go after the current one
    xfcp_pkg::xfcp_byte_t word_cnt;
    // Byte index within the header or the current data word
    logic [1:0] byte_cnt;
    // Final write byte carried the last flag
    logic last_q;

    logic up_xfer;
    logic down_xfer;
    logic is_write;
    logic hdr_bad;
    logic word_done;
    logic final_word;

    assign up_ready_o   = state inside {ST_HDR, ST_WDATA, ST_DRAIN};
    assign up_xfer      = up_valid_i && up_ready_o;
    assign down_valid_o = state inside {ST_RSP_HDR, ST_RDATA, ST_ERR};
    assign down_xfer    = down_valid_o && down_ready_i;

    assign is_write   = (op_q == xfcp_pkg::OP_WRITE_REQ);
    assign hdr_bad    = (route_q >= xfcp_pkg::NUM_BANKS) ||
                        !((op_q == xfcp_pkg::OP_READ_REQ) || is_write);
    assign word_done  = (byte_cnt == 2'(xfcp_pkg::BYTES_PER_WORD - 1));
    assign final_word = (word_cnt == '0);

    // Packer strobes follow the stream handshakes and the bus ack
    assign shift_in_o  = (state == ST_WDATA) && up_xfer;
    assign shift_out_o = (state == ST_RDATA) && down_xfer;
    assign load_o      = (state == ST_BUS) && wb_rsp_i.ack && !is_write;

    // Strobe drops on the cycle after ack because the FSM leaves ST_BUS
    always_comb begin
        wb_req_o.cyc = (state == ST_BUS);
        wb_req_o.stb = (state == ST_BUS);
        wb_req_o.we  = is_write;
        wb_req_o.adr = {route_q[0], word_addr};
        wb_req_o.dat = pack_word_i;
    end

    always_comb begin
        down_o.data = '0;
        down_o.last = 1'b0;
        case (state)
            ST_RSP_HDR: begin
                case (byte_cnt)
                    2'd0: down_o.data = route_q;
                    2'd1: down_o.data = is_write ? xfcp_pkg::OP_WRITE_RESP
                                                 : xfcp_pkg::OP_READ_RESP;
                    2'd2: down_o.data = addr_q;
                    default: down_o.data = count_q;
                endcase
                // A write response ends with its header
                down_o.last = (byte_cnt == 2'd3) && is_write;
            end
            ST_RDATA: begin
                down_o.data = pack_byte_i;
                down_o.last = word_done && final_word;
            end
            ST_ERR: begin
                down_o.data = (byte_cnt == 2'd0) ? route_q : xfcp_pkg::OP_ERROR;
                down_o.last = (byte_cnt != 2'd0);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= ST_HDR;
            route_q   <= '0;
            op_q      <= '0;
            addr_q    <= '0;
            count_q   <= '0;
            word_addr <= '0;
            word_cnt  <= '0;
            byte_cnt  <= '0;
            last_q    <= 1'b0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (up_xfer) begin
                        case (byte_cnt)
                            2'd0: route_q <= up_i.data;
                            2'd1: op_q <= up_i.data;
                            2'd2: begin
                                addr_q    <= up_i.data;
                                word_addr <= up_i.data;
                            end
                            default: begin
                                count_q  <= up_i.data;
                                word_cnt <= up_i.data;
                            end
                        endcase
                        byte_cnt <= byte_cnt + 2'd1;
                        // Route and opcode are already held when the count arrives
                        if (byte_cnt == 2'd3) begin
                            if (hdr_bad) begin
                                state <= up_i.last ? ST_ERR : ST_DRAIN;
                            end else if (is_write) begin
                                state <= up_i.last ? ST_HDR : ST_WDATA;
                            end else begin
                                state <= up_i.last ? ST_RSP_HDR : ST_DRAIN;
                            end
                        end else if (up_i.last) begin
                            // Short header, drop it
                            byte_cnt <= '0;
                        end
                    end
                end
                ST_WDATA: begin
                    if (up_xfer) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (word_done) begin
                            last_q <= up_i.last;
                            state  <= (up_i.last && !final_word) ? ST_HDR : ST_BUS;
                        end else if (up_i.last) begin
                            byte_cnt <= '0;
                            state    <= ST_HDR;
                        end
                    end
                end
                ST_BUS: begin
                    if (wb_rsp_i.ack) begin
                        if (!is_write) begin
                            state <= ST_RDATA;
                        end else if (!final_word) begin
                            word_cnt  <= word_cnt - 8'd1;
                            word_addr <= word_addr + 8'd1;
                            state     <= ST_WDATA;
                        end else begin
                            // Trailing bytes after the data still need draining
                            state <= last_q ? ST_RSP_HDR : ST_DRAIN;
                        end
                    end
                end
                ST_RSP_HDR: begin
                    if (down_xfer) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            state <= is_write ? ST_HDR : ST_BUS;
                        end
                    end
                end
                ST_RDATA: begin
                    if (down_xfer) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (word_done) begin
                            if (final_word) begin
                                state <= ST_HDR;
                            end else begin
                                word_cnt  <= word_cnt - 8'd1;
                                word_addr <= word_addr + 8'd1;
                                state     <= ST_BUS;
                            end
                        end
                    end
                end
                ST_ERR: begin
                    if (down_xfer) begin
                        if (byte_cnt == 2'd0) begin
                            byte_cnt <= 2'd1;
                        end else begin
                            byte_cnt <= '0;
                            state    <= ST_HDR;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (up_xfer && up_i.last) begin
                        state <= hdr_bad ? ST_ERR : ST_RSP_HDR;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

// ==== design/wb_pkg.sv ====
// Wishbone classic widths and bundles used between the command controller and the RAM slave
package wb_pkg;

    localparam int WB_DATA_W = 32;

    // Bank select bit on top of an 8-bit word address
    localparam int WB_ADDR_W = 9;

    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

    // Master to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Slave to master, dat is valid together with ack
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

// ==== design/xfcp_pkg.sv ====
// Packet protocol constants and stream byte types shared by the command controller and the top
package xfcp_pkg;

    // One byte on the request or response stream
    typedef logic [7:0] xfcp_byte_t;

    // One stream beat; last marks the final byte of a packet
    typedef struct packed {
        xfcp_byte_t data;
        logic       last;
    } xfcp_stream_t;

    // Request opcodes
    localparam xfcp_byte_t OP_READ_REQ   = 8'h10;
    localparam xfcp_byte_t OP_WRITE_REQ  = 8'h12;

    // Response opcodes are the request opcode with bit 0 set
    localparam xfcp_byte_t OP_READ_RESP  = 8'h11;
    localparam xfcp_byte_t OP_WRITE_RESP = 8'h13;

    // Sent back for a bad route or an unknown opcode
    localparam xfcp_byte_t OP_ERROR      = 8'hFE;

    // Data bytes carried per bus word, least significant first
    localparam int BYTES_PER_WORD = 4;

    // Route values 0 and 1 select a RAM bank; anything above is rejected
    localparam int NUM_BANKS = 2;

endpackage
